// ==== sim.f ====
+incdir+tb
verilog/exec_pkg.sv
verilog/exec_issue_if.sv
verilog/alu_decode.sv
verilog/simple_alu.sv
verilog/exec_lane.sv
tb/tb_exec_lane.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the execution lane testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_exec_lane -o tb_exec_lane
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_exec_lane)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== tb/alu_model.svh ====
// reference model of the simple integer lane
// expected destination, result and flags for one MIPS word and its operands

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic void predict_lane(
    input  logic [31:0] word,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [4:0]  dest,
    output logic [31:0] res,
    output logic [5:0]  flags
);
    logic [5:0]  op;
    logic [4:0]  sa;
    logic [31:0] sx;
    logic [31:0] zx;
    logic        known;
    logic        carry;
    op    = word[31:26];
    sa    = word[10:6];
    sx    = {{16{word[15]}}, word[15:0]};
    zx    = {16'h0000, word[15:0]};
    res   = '0;
    carry = 1'b0;
    known = 1'b1;
    dest  = (op == exec_pkg::MIPS_OP_SPECIAL) ? word[15:11] : word[20:16];  // rd or rt
    if (op == exec_pkg::MIPS_OP_SPECIAL) begin
        case (word[5:0])
            exec_pkg::MIPS_FN_ADD:  {carry, res} = {1'b0, a} + {1'b0, b};
            exec_pkg::MIPS_FN_ADDU: res = a + b;
            exec_pkg::MIPS_FN_SUB:  {carry, res} = {1'b0, a} - {1'b0, b};  // borrow out
            exec_pkg::MIPS_FN_SUBU: res = a - b;
            exec_pkg::MIPS_FN_MFHI, exec_pkg::MIPS_FN_MTHI,
            exec_pkg::MIPS_FN_MFLO, exec_pkg::MIPS_FN_MTLO: res = a;
            exec_pkg::MIPS_FN_AND:  res = a & b;
            exec_pkg::MIPS_FN_OR:   res = a | b;
            exec_pkg::MIPS_FN_XOR:  res = a ^ b;
            exec_pkg::MIPS_FN_NOR:  res = ~(a | b);
            exec_pkg::MIPS_FN_SLL:  res = a << sa;
            exec_pkg::MIPS_FN_SRL:  res = a >> sa;
            exec_pkg::MIPS_FN_SRA:  res = $signed(a) >>> sa;
            exec_pkg::MIPS_FN_SLLV: res = b << a[4:0];  // rs carries the amount
            exec_pkg::MIPS_FN_SRLV: res = b >> a[4:0];
            exec_pkg::MIPS_FN_SRAV: res = $signed(b) >>> a[4:0];
            exec_pkg::MIPS_FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            exec_pkg::MIPS_FN_SLTU: res = {31'd0, a < b};
            default:                known = 1'b0;
        endcase
    end else begin
        case (op)
            exec_pkg::MIPS_OP_ADDI:  {carry, res} = {1'b0, a} + {1'b0, sx};
            exec_pkg::MIPS_OP_ADDIU: res = a + sx;
            exec_pkg::MIPS_OP_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
            exec_pkg::MIPS_OP_SLTIU: res = {31'd0, a < zx};
            exec_pkg::MIPS_OP_ANDI:  res = a & zx;
            exec_pkg::MIPS_OP_ORI:   res = a | zx;
            exec_pkg::MIPS_OP_XORI:  res = a ^ zx;
            exec_pkg::MIPS_OP_LUI:   res = {word[15:0], 16'h0000};
            default:                 known = 1'b0;
        endcase
    end
    if (!known || word == '0) begin
        res   = '0;  // unsupported word or the all-zero nop
        carry = 1'b0;
    end
    if (!known) begin
        dest = '0;
    end
    flags                           = '0;
    flags[exec_pkg::FLAG_EXECUTED]  = known && (word != '0);
    flags[exec_pkg::FLAG_EXCEPTION] = !known;
    flags[exec_pkg::FLAG_DONE]      = 1'b1;
    flags[exec_pkg::FLAG_CARRY]     = carry;
endfunction

`endif

// ==== tb/tb_exec_lane.sv ====
// testbench for the simple integer execution lane
// LFSR stimulus, expected-result queue and a comparing process

`timescale 1ns/1ps

module tb_exec_lane;

    localparam int NUM_ISSUE = 3000;
    localparam int WAIT_MAX  = 40;  // cycles any single wait may take

    localparam logic [5:0] FN_LIST [20] = '{
        exec_pkg::MIPS_FN_SLL,  exec_pkg::MIPS_FN_SRL,  exec_pkg::MIPS_FN_SRA,
        exec_pkg::MIPS_FN_SLLV, exec_pkg::MIPS_FN_SRLV, exec_pkg::MIPS_FN_SRAV,
        exec_pkg::MIPS_FN_MFHI, exec_pkg::MIPS_FN_MTHI, exec_pkg::MIPS_FN_MFLO,
        exec_pkg::MIPS_FN_MTLO, exec_pkg::MIPS_FN_ADD,  exec_pkg::MIPS_FN_ADDU,
        exec_pkg::MIPS_FN_SUB,  exec_pkg::MIPS_FN_SUBU, exec_pkg::MIPS_FN_AND,
        exec_pkg::MIPS_FN_OR,   exec_pkg::MIPS_FN_XOR,  exec_pkg::MIPS_FN_NOR,
        exec_pkg::MIPS_FN_SLT,  exec_pkg::MIPS_FN_SLTU
    };
    localparam logic [5:0] OP_LIST [8] = '{
        exec_pkg::MIPS_OP_ADDI, exec_pkg::MIPS_OP_ADDIU, exec_pkg::MIPS_OP_SLTI,
        exec_pkg::MIPS_OP_SLTIU, exec_pkg::MIPS_OP_ANDI, exec_pkg::MIPS_OP_ORI,
        exec_pkg::MIPS_OP_XORI, exec_pkg::MIPS_OP_LUI
    };

    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [5:0]  flags;
    } expect_s;

    logic                          clk;
    logic                          rst_n_i;
    logic                          issue_valid_i;
    logic [31:0]                   instr_i;
    logic [exec_pkg::DATA_W-1:0]   data1_i;
    logic [exec_pkg::DATA_W-1:0]   data2_i;
    logic                          wb_valid_o;
    logic [exec_pkg::REG_W-1:0]    wb_dest_o;
    logic [exec_pkg::DATA_W-1:0]   wb_result_o;
    logic [exec_pkg::FLAGS_W-1:0]  wb_flags_o;

    logic [31:0] lfsr_q;
    expect_s     exp_q[$];
    int          err_cnt;
    int          checked_cnt;
    logic        checks_done;
    logic        timed_out;

    `include "alu_model.svh"

    exec_lane exec_lane_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .instr_i       (instr_i),
        .data1_i       (data1_i),
        .data2_i       (data2_i),
        .wb_valid_o    (wb_valid_o),
        .wb_dest_o     (wb_dest_o),
        .wb_result_o   (wb_result_o),
        .wb_flags_o    (wb_flags_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] make_word();
        logic [3:0]  kind;
        logic [31:0] word;
        int          idx;
        kind = 4'(take_bits(4));
        idx  = int'(5'(take_bits(5)) % 5'd28);
        if (kind == 4'd0) begin
            word = {6'h3f, 26'(take_bits(26))};  // unknown primary opcode
        end else if (kind == 4'd1) begin
            word = {6'h00, 20'(take_bits(20)), 6'h3f};  // unknown funct
        end else if (kind == 4'd2) begin
            word = '0;
        end else if (idx < 20) begin
            word = {6'h00, 20'(take_bits(20)), FN_LIST[idx]};
        end else begin
            word = {OP_LIST[idx-20], 26'(take_bits(26))};
        end
        return word;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            err_cnt++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    initial begin
        expect_s     e;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        int          waited;
        lfsr_q        = 32'hb398_6cb9;
        err_cnt       = 0;
        checked_cnt   = 0;
        timed_out     = 1'b0;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        instr_i       = '0;
        data1_i       = '0;
        data2_i       = '0;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            compare_field("wb_valid_o", 32'(1'b0), 32'(wb_valid_o));
        end
        rst_n_i <= 1'b1;
        for (int n = 0; n < NUM_ISSUE; n++) begin
            @(posedge clk);
            e.valid = (n >= 4) && (4'(take_bits(4)) != 4'd0);  // a few idle cycles first
            word    = make_word();
            a       = take_bits(32);
            b       = take_bits(32);
            if (take_bits(3) == 0) begin
                b = a;  // equal operands for compares and zero differences
            end
            predict_lane(word, a, b, e.dest, e.result, e.flags);
            issue_valid_i <= e.valid;
            instr_i       <= word;
            data1_i       <= a;
            data2_i       <= b;
            exp_q.push_back(e);
        end
        @(posedge clk);
        issue_valid_i <= 1'b0;
        waited = 0;
        while (!checks_done && !timed_out && waited < WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (!checks_done && !timed_out) begin
            $display("timeout: the comparing process did not drain the expected queue");
            timed_out = 1'b1;
        end
        $display("checked %0d results, %0d value errors, %0d timeouts",
                 checked_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // results are sampled on the falling edge, two cycles after the issue edge
    initial begin
        expect_s e;
        int      waited;
        checks_done = 1'b0;
        waited      = 0;
        @(negedge clk);
        while (exp_q.size() == 0 && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() == 0) begin
            $display("timeout: no instruction was issued after reset");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            @(posedge clk);
            while (exp_q.size() > 0) begin
                @(negedge clk);
                e = exp_q.pop_front();
                compare_field("wb_valid_o", 32'(e.valid), 32'(wb_valid_o));
                if (e.valid) begin
                    compare_field("wb_dest_o", 32'(e.dest), 32'(wb_dest_o));
                    compare_field("wb_result_o", e.result, wb_result_o);
                    compare_field("wb_flags_o", 32'(e.flags), 32'(wb_flags_o));
                end
                checked_cnt++;
            end
        end
        checks_done = 1'b1;
    end

endmodule

// ==== verilog/exec_lane.sv ====
// simple integer execution lane, top level
// decode stage, combinational ALU and the writeback register
// two cycles from issue to writeback, one result per cycle

`timescale 1ns/1ps

module exec_lane (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         issue_valid_i,
    input  exec_pkg::instr_word_u        instr_i,
    input  logic [exec_pkg::DATA_W-1:0]  data1_i,
    input  logic [exec_pkg::DATA_W-1:0]  data2_i,
    output logic                         wb_valid_o,
    output logic [exec_pkg::REG_W-1:0]   wb_dest_o,
    output logic [exec_pkg::DATA_W-1:0]  wb_result_o,
    output logic [exec_pkg::FLAGS_W-1:0] wb_flags_o
);

    logic [exec_pkg::DATA_W-1:0]  alu_result;
    logic [exec_pkg::FLAGS_W-1:0] alu_flags;

    exec_issue_if issue_if ();

    alu_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .instr_i       (instr_i),
        .data1_i       (data1_i),
        .data2_i       (data2_i),
        .pkt_o         (issue_if.producer)
    );

    simple_alu u_alu (
        .pkt_i    (issue_if.consumer),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o  <= 1'b0;
            wb_dest_o   <= '0;
            wb_result_o <= '0;
            wb_flags_o  <= '0;
        end else begin
            wb_valid_o  <= issue_if.valid;
            wb_dest_o   <= issue_if.dest;
            wb_result_o <= alu_result;
            wb_flags_o  <= alu_flags;  // data is don't-care when valid is low
        end
    end

    // decode rejects a word by turning it into a NOP, so it can never execute
    wb_done_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> wb_flags_o[exec_pkg::FLAG_DONE]);
    wb_exc_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> !(wb_flags_o[exec_pkg::FLAG_EXECUTED] &&
                         wb_flags_o[exec_pkg::FLAG_EXCEPTION]));

endmodule

// ==== verilog/simple_alu.sv ====
// combinational simple integer ALU
// computes result and execution flags from a decoded issue packet

`timescale 1ns/1ps

module simple_alu (
    exec_issue_if.consumer                pkt_i,
    output logic [exec_pkg::DATA_W-1:0]   result_o,
    output logic [exec_pkg::FLAGS_W-1:0]  flags_o
);

    logic [exec_pkg::DATA_W-1:0]  sign_immd;
    logic [exec_pkg::DATA_W-1:0]  zero_immd;
    logic [exec_pkg::SHAMT_W-1:0] fix_shamt;
    logic [exec_pkg::SHAMT_W-1:0] var_shamt;
    logic                         carry;
    logic                         executed;

    assign sign_immd = {{(exec_pkg::DATA_W-exec_pkg::IMMD_W){pkt_i.immd[exec_pkg::IMMD_W-1]}},
                        pkt_i.immd};
    assign zero_immd = {{(exec_pkg::DATA_W-exec_pkg::IMMD_W){1'b0}}, pkt_i.immd};
    assign fix_shamt = pkt_i.immd[exec_pkg::SHAMT_W-1:0];   // shamt field from decode
    assign var_shamt = pkt_i.data1[exec_pkg::SHAMT_W-1:0];  // rs holds the amount

    always_comb begin
        result_o = '0;
        carry    = 1'b0;
        executed = 1'b1;
        case (pkt_i.opcode)
            exec_pkg::ALU_ADD: begin
                {carry, result_o} = {1'b0, pkt_i.data1} + {1'b0, pkt_i.data2};
            end
            exec_pkg::ALU_ADDI: begin
                {carry, result_o} = {1'b0, pkt_i.data1} + {1'b0, sign_immd};
            end
            exec_pkg::ALU_ADDU: begin
                result_o = pkt_i.data1 + pkt_i.data2;
            end
            exec_pkg::ALU_ADDIU: begin
                result_o = pkt_i.data1 + sign_immd;
            end
            exec_pkg::ALU_SUB: begin
                {carry, result_o} = {1'b0, pkt_i.data1} - {1'b0, pkt_i.data2};  // carry is borrow
            end
            exec_pkg::ALU_SUBU: begin
                result_o = pkt_i.data1 - pkt_i.data2;
            end
            // HI/LO live outside the lane, the moves just forward rs
            exec_pkg::ALU_MFHI,
            exec_pkg::ALU_MTHI,
            exec_pkg::ALU_MFLO,
            exec_pkg::ALU_MTLO: begin
                result_o = pkt_i.data1;
            end
            exec_pkg::ALU_AND: begin
                result_o = pkt_i.data1 & pkt_i.data2;
            end
            exec_pkg::ALU_ANDI: begin
                result_o = pkt_i.data1 & zero_immd;
            end
            exec_pkg::ALU_OR: begin
                result_o = pkt_i.data1 | pkt_i.data2;
            end
            exec_pkg::ALU_ORI: begin
                result_o = pkt_i.data1 | zero_immd;
            end
            exec_pkg::ALU_XOR: begin
                result_o = pkt_i.data1 ^ pkt_i.data2;
            end
            exec_pkg::ALU_XORI: begin
                result_o = pkt_i.data1 ^ zero_immd;
            end
            exec_pkg::ALU_NOR: begin
                result_o = ~(pkt_i.data1 | pkt_i.data2);
            end
            exec_pkg::ALU_SLL: begin
                result_o = pkt_i.data1 << fix_shamt;
            end
            exec_pkg::ALU_SLLV: begin
                result_o = pkt_i.data2 << var_shamt;
            end
            exec_pkg::ALU_SRL: begin
                result_o = pkt_i.data1 >> fix_shamt;
            end
            exec_pkg::ALU_SRLV: begin
                result_o = pkt_i.data2 >> var_shamt;
            end
            exec_pkg::ALU_SRA: begin
                result_o = $signed(pkt_i.data1) >>> fix_shamt;
            end
            exec_pkg::ALU_SRAV: begin
                result_o = $signed(pkt_i.data2) >>> var_shamt;
            end
            exec_pkg::ALU_SLT: begin
                result_o[0] = $signed(pkt_i.data1) < $signed(pkt_i.data2);
            end
            exec_pkg::ALU_SLTI: begin
                result_o[0] = $signed(pkt_i.data1) < $signed(sign_immd);
            end
            exec_pkg::ALU_SLTU: begin
                result_o[0] = pkt_i.data1 < pkt_i.data2;
            end
            exec_pkg::ALU_SLTIU: begin
                result_o[0] = pkt_i.data1 < zero_immd;
            end
            exec_pkg::ALU_LUI: begin
                result_o = {pkt_i.immd, {(exec_pkg::DATA_W-exec_pkg::IMMD_W){1'b0}}};
            end
            default: begin
                executed = 1'b0;  // NOP and rejected words leave the result at zero
            end
        endcase
    end

    always_comb begin
        flags_o                           = '0;
        flags_o[exec_pkg::FLAG_EXECUTED]  = executed;
        flags_o[exec_pkg::FLAG_EXCEPTION] = pkt_i.bad_instr;
        flags_o[exec_pkg::FLAG_DONE]      = 1'b1;  // every op completes in one pass
        flags_o[exec_pkg::FLAG_CARRY]     = carry;
    end

endmodule

// ==== verilog/alu_decode.sv ====
// decode stage of the simple integer lane
// maps a MIPS word to an internal ALU opcode, immediate and destination
// and registers the result together with the operands

`timescale 1ns/1ps

module alu_decode (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        issue_valid_i,
    input  exec_pkg::instr_word_u       instr_i,
    input  logic [exec_pkg::DATA_W-1:0] data1_i,
    input  logic [exec_pkg::DATA_W-1:0] data2_i,
    exec_issue_if.producer              pkt_o
);

    exec_pkg::alu_op_e              op_d;
    logic [exec_pkg::IMMD_W-1:0]    immd_d;
    logic [exec_pkg::REG_W-1:0]     dest_d;
    logic                           bad_d;

    always_comb begin
        op_d   = exec_pkg::ALU_NOP;
        bad_d  = 1'b0;
        immd_d = instr_i.i.imm;
        dest_d = instr_i.i.rt;  // immediate format writes rt
        if (instr_i.r.op == exec_pkg::MIPS_OP_SPECIAL) begin
            dest_d = instr_i.r.rd;
            immd_d = {{(exec_pkg::IMMD_W-exec_pkg::SHAMT_W){1'b0}}, instr_i.r.shamt};
            case (instr_i.r.funct)
                exec_pkg::MIPS_FN_SLL:  op_d = exec_pkg::ALU_SLL;
                exec_pkg::MIPS_FN_SRL:  op_d = exec_pkg::ALU_SRL;
                exec_pkg::MIPS_FN_SRA:  op_d = exec_pkg::ALU_SRA;
                exec_pkg::MIPS_FN_SLLV: op_d = exec_pkg::ALU_SLLV;
                exec_pkg::MIPS_FN_SRLV: op_d = exec_pkg::ALU_SRLV;
                exec_pkg::MIPS_FN_SRAV: op_d = exec_pkg::ALU_SRAV;
                exec_pkg::MIPS_FN_MFHI: op_d = exec_pkg::ALU_MFHI;
                exec_pkg::MIPS_FN_MTHI: op_d = exec_pkg::ALU_MTHI;
                exec_pkg::MIPS_FN_MFLO: op_d = exec_pkg::ALU_MFLO;
                exec_pkg::MIPS_FN_MTLO: op_d = exec_pkg::ALU_MTLO;
                exec_pkg::MIPS_FN_ADD:  op_d = exec_pkg::ALU_ADD;
                exec_pkg::MIPS_FN_ADDU: op_d = exec_pkg::ALU_ADDU;
                exec_pkg::MIPS_FN_SUB:  op_d = exec_pkg::ALU_SUB;
                exec_pkg::MIPS_FN_SUBU: op_d = exec_pkg::ALU_SUBU;
                exec_pkg::MIPS_FN_AND:  op_d = exec_pkg::ALU_AND;
                exec_pkg::MIPS_FN_OR:   op_d = exec_pkg::ALU_OR;
                exec_pkg::MIPS_FN_XOR:  op_d = exec_pkg::ALU_XOR;
                exec_pkg::MIPS_FN_NOR:  op_d = exec_pkg::ALU_NOR;
                exec_pkg::MIPS_FN_SLT:  op_d = exec_pkg::ALU_SLT;
                exec_pkg::MIPS_FN_SLTU: op_d = exec_pkg::ALU_SLTU;
                default:                bad_d = 1'b1;
            endcase
        end else begin
            case (instr_i.i.op)
                exec_pkg::MIPS_OP_ADDI:  op_d = exec_pkg::ALU_ADDI;
                exec_pkg::MIPS_OP_ADDIU: op_d = exec_pkg::ALU_ADDIU;
                exec_pkg::MIPS_OP_SLTI:  op_d = exec_pkg::ALU_SLTI;
                exec_pkg::MIPS_OP_SLTIU: op_d = exec_pkg::ALU_SLTIU;
                exec_pkg::MIPS_OP_ANDI:  op_d = exec_pkg::ALU_ANDI;
                exec_pkg::MIPS_OP_ORI:   op_d = exec_pkg::ALU_ORI;
                exec_pkg::MIPS_OP_XORI:  op_d = exec_pkg::ALU_XORI;
                exec_pkg::MIPS_OP_LUI:   op_d = exec_pkg::ALU_LUI;
                default:                 bad_d = 1'b1;
            endcase
        end
        // the all-zero word is the canonical MIPS nop (sll r0, r0, 0)
        if (instr_i == '0) begin
            op_d = exec_pkg::ALU_NOP;
        end
        if (bad_d) begin
            op_d   = exec_pkg::ALU_NOP;
            dest_d = '0;  // a faulting word targets r0, so nothing is written
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_o.valid     <= 1'b0;
            pkt_o.opcode    <= exec_pkg::ALU_NOP;
            pkt_o.immd      <= '0;
            pkt_o.data1     <= '0;
            pkt_o.data2     <= '0;
            pkt_o.dest      <= '0;
            pkt_o.bad_instr <= 1'b0;
        end else begin
            pkt_o.valid     <= issue_valid_i;
            pkt_o.opcode    <= op_d;
            pkt_o.immd      <= immd_d;
            pkt_o.data1     <= data1_i;
            pkt_o.data2     <= data2_i;
            pkt_o.dest      <= dest_d;
            pkt_o.bad_instr <= bad_d;
        end
    end

    // the writeback stage relies on a clean valid bit every cycle
    valid_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(pkt_o.valid));

endmodule

// ==== verilog/exec_issue_if.sv ====
// decoded issue packet from the decode stage to the ALU stage
// fields are registered and hold for a full cycle, no handshake

`timescale 1ns/1ps

interface exec_issue_if;

    logic                          valid;
    exec_pkg::alu_op_e             opcode;
    logic [exec_pkg::IMMD_W-1:0]   immd;       // immediate or zero-extended shamt
    logic [exec_pkg::DATA_W-1:0]   data1;
    logic [exec_pkg::DATA_W-1:0]   data2;
    logic [exec_pkg::REG_W-1:0]    dest;
    logic                          bad_instr;  // word was not a simple ALU instruction

    modport producer (
        output valid, opcode, immd, data1, data2, dest, bad_instr
    );

    modport consumer (
        input valid, opcode, immd, data1, data2, dest, bad_instr
    );

endinterface

// ==== verilog/exec_pkg.sv ====
// shared widths, internal ALU opcodes and execution flag positions
// MIPS primary opcode and function codes recognised by the lane
// register and immediate views of the instruction word

package exec_pkg;

    localparam int DATA_W  = 32;  // operand and result width
    localparam int IMMD_W  = 16;
    localparam int REG_W   = 5;   // architectural register index
    localparam int FLAGS_W = 6;
    localparam int OP_W    = 6;   // MIPS opcode and funct field width
    localparam int SHAMT_W = 5;

    // bits 5 and 0 of the flag word are reserved and stay zero
    localparam int FLAG_EXECUTED  = 4;
    localparam int FLAG_EXCEPTION = 3;
    localparam int FLAG_DONE      = 2;
    localparam int FLAG_CARRY     = 1;  // carry or borrow, ADD/ADDI/SUB only

    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDI, ALU_ADDU, ALU_ADDIU, ALU_SUB, ALU_SUBU,
        ALU_MFHI, ALU_MTHI, ALU_MFLO, ALU_MTLO,
        ALU_AND, ALU_ANDI, ALU_OR, ALU_ORI, ALU_XOR, ALU_XORI, ALU_NOR,
        ALU_SLL, ALU_SLLV, ALU_SRL, ALU_SRLV, ALU_SRA, ALU_SRAV,
        ALU_SLT, ALU_SLTI, ALU_SLTU, ALU_SLTIU,
        ALU_LUI, ALU_NOP
    } alu_op_e;

    localparam logic [OP_W-1:0] MIPS_OP_SPECIAL = 6'h00;  // register format, decoded by funct
    localparam logic [OP_W-1:0] MIPS_OP_ADDI    = 6'h08;
    localparam logic [OP_W-1:0] MIPS_OP_ADDIU   = 6'h09;
    localparam logic [OP_W-1:0] MIPS_OP_SLTI    = 6'h0a;
    localparam logic [OP_W-1:0] MIPS_OP_SLTIU   = 6'h0b;
    localparam logic [OP_W-1:0] MIPS_OP_ANDI    = 6'h0c;
    localparam logic [OP_W-1:0] MIPS_OP_ORI     = 6'h0d;
    localparam logic [OP_W-1:0] MIPS_OP_XORI    = 6'h0e;
    localparam logic [OP_W-1:0] MIPS_OP_LUI     = 6'h0f;

    localparam logic [OP_W-1:0] MIPS_FN_SLL  = 6'h00;
    localparam logic [OP_W-1:0] MIPS_FN_SRL  = 6'h02;
    localparam logic [OP_W-1:0] MIPS_FN_SRA  = 6'h03;
    localparam logic [OP_W-1:0] MIPS_FN_SLLV = 6'h04;
    localparam logic [OP_W-1:0] MIPS_FN_SRLV = 6'h06;
    localparam logic [OP_W-1:0] MIPS_FN_SRAV = 6'h07;
    localparam logic [OP_W-1:0] MIPS_FN_MFHI = 6'h10;
    localparam logic [OP_W-1:0] MIPS_FN_MTHI = 6'h11;
    localparam logic [OP_W-1:0] MIPS_FN_MFLO = 6'h12;
    localparam logic [OP_W-1:0] MIPS_FN_MTLO = 6'h13;
    localparam logic [OP_W-1:0] MIPS_FN_ADD  = 6'h20;
    localparam logic [OP_W-1:0] MIPS_FN_ADDU = 6'h21;
    localparam logic [OP_W-1:0] MIPS_FN_SUB  = 6'h22;
    localparam logic [OP_W-1:0] MIPS_FN_SUBU = 6'h23;
    localparam logic [OP_W-1:0] MIPS_FN_AND  = 6'h24;
    localparam logic [OP_W-1:0] MIPS_FN_OR   = 6'h25;
    localparam logic [OP_W-1:0] MIPS_FN_XOR  = 6'h26;
    localparam logic [OP_W-1:0] MIPS_FN_NOR  = 6'h27;
    localparam logic [OP_W-1:0] MIPS_FN_SLT  = 6'h2a;
    localparam logic [OP_W-1:0] MIPS_FN_SLTU = 6'h2b;

    typedef struct packed {
        logic [OP_W-1:0]    op;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        logic [OP_W-1:0]    funct;
    } r_fmt_s;

    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic [IMMD_W-1:0] imm;
    } i_fmt_s;

    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
    } instr_word_u;

endpackage
